// File: design/sys_consts.svh
// -------------------------------------------------------------------------
// Address map, register offsets and sizing constants
// -------------------------------------------------------------------------

`ifndef SYS_CONSTS_SVH
`define SYS_CONSTS_SVH

// Top address byte of each slave
`define SYS_BASE_RAM    8'h00
`define SYS_BASE_GPIO   8'h02
`define SYS_BASE_TIMER  8'h05

// RAM depth in 32-bit words
`define SYS_RAM_WORDS   256
// Cycles the slaves stay in reset after rst_n rises
`define SYS_RST_HOLD    16

// GPIO byte offsets
`define GPIO_REG_OUT    0
`define GPIO_REG_OE     4
`define GPIO_REG_IN     8

// Timer byte offsets
`define TMR_REG_LOAD    0
`define TMR_REG_COUNT   4
`define TMR_REG_CTRL    8
`define TMR_REG_STATUS  12

`endif

// File: design/sys_pkg.sv
// -------------------------------------------------------------------------
// Shared types for the peripheral bus subsystem
// Bus structs for the forward and return directions, timer state enum
// and the byte lane merge helper used by the writable slaves
// -------------------------------------------------------------------------

package sys_pkg;

    // Master to slave, 69 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        // All zero marks a read
        logic [3:0]  wstrb;
    } bus_fwd_t;

    // Slave to master, 33 bits, zero when not selected
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_ret_t;

    // Timer FSM
    typedef enum logic [1:0] {
        TMR_IDLE = 2'd0,
        TMR_RUN  = 2'd1,
        TMR_DONE = 2'd2
    } timer_state_e;

    // Replace the bytes of old_word selected by strb
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = new_word[8*i +: 8];
        end
        return res;
    endfunction

endpackage

// File: design/reset_gen.sv
// -------------------------------------------------------------------------
// Reset stretcher
// Holds the internal slave reset low for a fixed count after rst_n rises
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sys_consts.svh"

module reset_gen (
    input  logic clk,
    input  logic rst_n,
    output logic sys_rst_n
);

    // Wide enough to hold the full hold count
    localparam int CW = $clog2(`SYS_RST_HOLD + 1);

    logic [CW-1:0] cnt;
    logic          cnt_full;

    assign cnt_full = (cnt == CW'(`SYS_RST_HOLD));

    // Saturating count, restarted by every external reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            sys_rst_n <= 1'b0;
        end else begin
            if (!cnt_full) cnt <= cnt + 1'b1;
            // Registered so release lands exactly HOLD edges after the first
            sys_rst_n <= cnt_full;
        end
    end

endmodule

// File: design/bram_port.sv
// -------------------------------------------------------------------------
// Block RAM slave
// Word addressed memory with byte lane writes and a one cycle response
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sys_consts.svh"

module bram_port #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input  logic              clk,
    input  logic              rst_n,
    input  sys_pkg::bus_fwd_t bus_fwd,
    output sys_pkg::bus_ret_t bus_ret
);

    import sys_pkg::*;

    localparam int AW = $clog2(`SYS_RAM_WORDS);

    logic [31:0]   mem [`SYS_RAM_WORDS];
    logic          acc;
    logic          we;
    logic [AW-1:0] idx;

    // Selected and not already answering this access
    assign acc = bus_fwd.valid && (bus_fwd.addr[31:24] == BASE_ADDR) && !bus_ret.ready;
    assign we  = rst_n && acc && (bus_fwd.wstrb != 4'b0000);

    // Word index, wraps modulo the depth
    assign idx = bus_fwd.addr[AW+1:2];

    // ---------------------------------------------------------------------------
    // Storage
    // ---------------------------------------------------------------------------
    // Write lands on the same edge that raises ready
    always_ff @(posedge clk) begin
        if (we) mem[idx] <= merge_bytes(mem[idx], bus_fwd.wdata, bus_fwd.wstrb);
    end

    // ---------------------------------------------------------------------------
    // Response
    // ---------------------------------------------------------------------------
    // Read sees the old word, the write above is nonblocking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_ret.ready <= 1'b0;
            bus_ret.rdata <= '0;
        end else begin
            bus_ret.ready <= acc;
            // Zero when idle so the top level can OR the returns
            bus_ret.rdata <= acc ? mem[idx] : '0;
        end
    end

endmodule

// File: design/gpio_regs.sv
// -------------------------------------------------------------------------
// GPIO slave
// OUT and OE registers driving the pads, synchronized IN register
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sys_consts.svh"

module gpio_regs #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input  logic              clk,
    input  logic              rst_n,
    input  sys_pkg::bus_fwd_t bus_fwd,
    output sys_pkg::bus_ret_t bus_ret,
    input  logic [31:0]       gpio_in,
    output logic [31:0]       gpio_out,
    output logic [31:0]       gpio_oe
);

    import sys_pkg::*;

    logic        acc;
    logic        wr;
    logic [7:0]  ofs;
    logic [31:0] in_meta;
    logic [31:0] in_sync;
    logic [31:0] rd_word;

    assign acc = bus_fwd.valid && (bus_fwd.addr[31:24] == BASE_ADDR) && !bus_ret.ready;
    assign wr  = acc && (bus_fwd.wstrb != 4'b0000);
    assign ofs = bus_fwd.addr[7:0];

    // Two flop synchronizer, second stage is the IN register
    always_ff @(posedge clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    // Register read mux, unmapped offsets read zero
    always_comb begin
        case (ofs)
            8'(`GPIO_REG_OUT): rd_word = gpio_out;
            8'(`GPIO_REG_OE):  rd_word = gpio_oe;
            8'(`GPIO_REG_IN):  rd_word = in_sync;
            default:           rd_word = '0;
        endcase
    end

    // Pad registers, IN is read only and ignores writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            gpio_oe  <= '0;
        end else if (wr) begin
            if (ofs == 8'(`GPIO_REG_OUT))
                gpio_out <= merge_bytes(gpio_out, bus_fwd.wdata, bus_fwd.wstrb);
            if (ofs == 8'(`GPIO_REG_OE))
                gpio_oe <= merge_bytes(gpio_oe, bus_fwd.wdata, bus_fwd.wstrb);
        end
    end

    // One cycle response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_ret.ready <= 1'b0;
            bus_ret.rdata <= '0;
        end else begin
            bus_ret.ready <= acc;
            bus_ret.rdata <= acc ? rd_word : '0;
        end
    end

endmodule

// File: design/timer_irq.sv
// -------------------------------------------------------------------------
// Down counting timer slave
// LOAD, COUNT, CTRL and STATUS registers, one shot or auto reload,
// level interrupt from the expired flag
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sys_consts.svh"

module timer_irq #(
    parameter logic [7:0] BASE_ADDR = 8'h00
) (
    input  logic              clk,
    input  logic              rst_n,
    input  sys_pkg::bus_fwd_t bus_fwd,
    output sys_pkg::bus_ret_t bus_ret,
    output logic              irq
);

    import sys_pkg::*;

    timer_state_e state;
    logic         acc;
    logic         wr;
    logic [7:0]   ofs;
    logic [31:0]  load_q;
    logic [31:0]  count_q;
    // Bit 0 enable, bit 1 auto reload, bit 2 interrupt enable
    logic [2:0]   ctrl_q;
    logic         expired;
    logic [31:0]  ctrl_new;
    logic [31:0]  rd_word;

    assign acc      = bus_fwd.valid && (bus_fwd.addr[31:24] == BASE_ADDR) && !bus_ret.ready;
    assign wr       = acc && (bus_fwd.wstrb != 4'b0000);
    assign ofs      = bus_fwd.addr[7:0];
    assign ctrl_new = merge_bytes({29'b0, ctrl_q}, bus_fwd.wdata, bus_fwd.wstrb);
    assign irq      = expired & ctrl_q[2];

    always_comb begin
        case (ofs)
            8'(`TMR_REG_LOAD):   rd_word = load_q;
            8'(`TMR_REG_COUNT):  rd_word = count_q;
            8'(`TMR_REG_CTRL):   rd_word = {29'b0, ctrl_q};
            8'(`TMR_REG_STATUS): rd_word = {31'b0, expired};
            default:             rd_word = '0;
        endcase
    end

    // ---------------------------------------------------------------------------
    // Counter FSM and registers
    // ---------------------------------------------------------------------------
    // Later statements win, so a CTRL write overrides counting
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TMR_IDLE;
            load_q  <= '0;
            count_q <= '0;
            ctrl_q  <= '0;
            expired <= 1'b0;
        end else begin
            // Write one to clear, a same cycle expiry still wins
            if (wr && ofs == 8'(`TMR_REG_STATUS) && bus_fwd.wstrb[0] && bus_fwd.wdata[0])
                expired <= 1'b0;
            if (state == TMR_RUN) begin
                if (count_q <= 32'd1) begin
                    expired <= 1'b1;
                    if (ctrl_q[1]) begin
                        count_q <= load_q;
                    end else begin
                        count_q <= '0;
                        state   <= TMR_DONE;
                    end
                end else begin
                    count_q <= count_q - 32'd1;
                end
            end
            if (wr && ofs == 8'(`TMR_REG_LOAD))
                load_q <= merge_bytes(load_q, bus_fwd.wdata, bus_fwd.wstrb);
            if (wr && ofs == 8'(`TMR_REG_CTRL)) begin
                ctrl_q <= ctrl_new[2:0];
                if (ctrl_new[0]) begin
                    // Restart from the current LOAD value
                    count_q <= load_q;
                    state   <= TMR_RUN;
                end else begin
                    // Disabling drops any pending expiry too
                    state   <= TMR_IDLE;
                    expired <= 1'b0;
                end
            end
        end
    end

    // One cycle response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_ret.ready <= 1'b0;
            bus_ret.rdata <= '0;
        end else begin
            bus_ret.ready <= acc;
            bus_ret.rdata <= acc ? rd_word : '0;
        end
    end

endmodule

// File: design/sys_top.sv
// -------------------------------------------------------------------------
// Peripheral subsystem top level
// Reset stretcher, RAM, GPIO and timer slaves on one native bus,
// slave returns combined by OR
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sys_consts.svh"

module sys_top (
    input  logic              clk,
    input  logic              rst_n,
    input  sys_pkg::bus_fwd_t bus_fwd,
    output sys_pkg::bus_ret_t bus_ret,
    input  logic [31:0]       gpio_in,
    output logic [31:0]       gpio_out,
    output logic [31:0]       gpio_oe,
    output logic              irq,
    output logic              sys_ready
);

    import sys_pkg::*;

    logic     sys_rst_n;
    bus_ret_t ram_ret;
    bus_ret_t gpio_ret;
    bus_ret_t tmr_ret;

    // ---------------------------------------------------------------------------
    // Internal reset
    // ---------------------------------------------------------------------------
    reset_gen u_rst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys_rst_n (sys_rst_n)
    );

    assign sys_ready = sys_rst_n;

    // ---------------------------------------------------------------------------
    // Slaves
    // ---------------------------------------------------------------------------
    bram_port #(.BASE_ADDR(`SYS_BASE_RAM)) u_ram (
        .clk     (clk),
        .rst_n   (sys_rst_n),
        .bus_fwd (bus_fwd),
        .bus_ret (ram_ret)
    );

    gpio_regs #(.BASE_ADDR(`SYS_BASE_GPIO)) u_gpio (
        .clk      (clk),
        .rst_n    (sys_rst_n),
        .bus_fwd  (bus_fwd),
        .bus_ret  (gpio_ret),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    timer_irq #(.BASE_ADDR(`SYS_BASE_TIMER)) u_timer (
        .clk     (clk),
        .rst_n   (sys_rst_n),
        .bus_fwd (bus_fwd),
        .bus_ret (tmr_ret),
        .irq     (irq)
    );

    // Idle slaves return zeros, so OR is enough
    assign bus_ret = bus_ret_t'(ram_ret | gpio_ret | tmr_ret);

endmodule

// File: tb/sys_top_sva.sv
// -------------------------------------------------------------------------
// Bus protocol assertions, bound into the subsystem top level
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module sys_top_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  sys_ready,
    input logic                  ram_ready,
    input logic                  gpio_ready,
    input logic                  tmr_ready,
    input sys_pkg::timer_state_e tmr_state,
    input logic                  irq
);

    import sys_pkg::*;

    logic any_ready;

    assign any_ready = ram_ready | gpio_ready | tmr_ready;

    // A response is a single cycle pulse
    a_ready_pulse: assert property (@(posedge clk) disable iff (!sys_ready)
        any_ready |=> !any_ready)
        else $error("bus ready stayed high for two cycles");

    // One slave answers at a time
    a_one_slave: assert property (@(posedge clk) disable iff (!sys_ready)
        $onehot0({ram_ready, gpio_ready, tmr_ready}))
        else $error("more than one slave raised ready");

    // Slaves stay silent during the internal reset
    a_quiet_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !sys_ready |-> !any_ready)
        else $error("ready raised while sys_ready was low");

    a_idle_irq: assert property (@(posedge clk) disable iff (!sys_ready)
        (tmr_state == TMR_IDLE) |-> !irq)
        else $error("irq high while the timer is idle");

endmodule

bind sys_top sys_top_sva i_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .sys_ready  (sys_ready),
    .ram_ready  (ram_ret.ready),
    .gpio_ready (gpio_ret.ready),
    .tmr_ready  (tmr_ret.ready),
    .tmr_state  (u_timer.state),
    .irq        (irq)
);

// File: tb/sys_top_tb.sv
// -------------------------------------------------------------------------
// Testbench for the peripheral subsystem
// Clock and reset, bus master tasks, LFSR stimulus, RAM and GPIO models,
// compare tasks, watchdog and closing report
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "sys_consts.svh"

module sys_top_tb;

    import sys_pkg::*;

    // Starts low so the first falling edge is at 20 ns
    logic        clk = 1'b0;
    logic        rst_n;
    bus_fwd_t    bus_fwd;
    bus_ret_t    bus_ret;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic [31:0] gpio_oe;
    logic        irq;
    logic        sys_ready;

    // Stimulus state and models
    logic [15:0] lfsr_q;
    logic [31:0] ram_model [`SYS_RAM_WORDS];
    bit          ram_known [`SYS_RAM_WORDS];
    logic [31:0] out_model;
    logic [31:0] oe_model;

    // Bookkeeping
    string       cur_test;
    int          errors;
    int          checks;
    int          test_errs;
    int          tests_run;
    int          tests_bad;

    sys_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_fwd   (bus_fwd),
        .bus_ret   (bus_ret),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe),
        .irq       (irq),
        .sys_ready (sys_ready)
    );

    // 20 ns clock
    initial begin
        forever #10 clk = ~clk;
    end

    // Watchdog over the reset hold plus the whole test budget
    initial begin
        #((`SYS_RST_HOLD + 4000) * 20);
        $display("Watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Each strobe bit covers one byte lane
    function automatic logic [31:0] lane_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // Slave base in the top byte and offset below
    function automatic logic [31:0] reg_addr(input logic [7:0] base, input int ofs);
        return {base, 24'(ofs)};
    endfunction

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s %s: expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errs) begin
            $display("test %s passed", cur_test);
        end else begin
            tests_bad++;
            $display("test %s failed with %0d errors", cur_test, errors - test_errs);
        end
    endtask

    // -------------------------------------------------------------------------
    // Bus master entered and left on a falling edge
    // -------------------------------------------------------------------------
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
        int waited;
        waited = 0;
        // Let a previous response end first
        if (bus_ret.ready) @(negedge clk);
        bus_fwd.valid = 1'b1;
        bus_fwd.addr  = addr;
        bus_fwd.wdata = wdata;
        bus_fwd.wstrb = wstrb;
        do begin
            @(negedge clk);
            waited++;
        end while (!bus_ret.ready && waited < 8);
        rdata = bus_ret.rdata;
        if (!bus_ret.ready)
            report_fail($sformatf("no ready came from the slave at address %h", addr));
        bus_fwd = '0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
        logic [31:0] unused;
        bus_access(addr, wdata, wstrb, unused);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_access(addr, '0, 4'h0, rdata);
    endtask

    task automatic wait_irq(input int limit);
        int k;
        k = 0;
        while (!irq && k < limit) begin
            @(negedge clk);
            k++;
        end
        if (!irq) report_fail($sformatf("irq did not rise within %0d cycles", limit));
    endtask

    // -------------------------------------------------------------------------
    // Tests
    // -------------------------------------------------------------------------
    task automatic reset_release();
        begin_test("reset_release");
        repeat (3) begin
            @(negedge clk);
            compare_bit("sys_ready in reset", 1'b0, sys_ready);
        end
        rst_n = 1'b1;
        // Low for the whole hold count and high on the edge after it
        repeat (`SYS_RST_HOLD) begin
            @(negedge clk);
            compare_bit("sys_ready during hold", 1'b0, sys_ready);
        end
        @(negedge clk);
        compare_bit("sys_ready after hold", 1'b1, sys_ready);
        end_test();
    endtask

    task automatic ram_byte_writes();
        int          idx;
        logic [31:0] d;
        logic [3:0]  s;
        logic [31:0] m;
        logic [31:0] v;
        begin_test("ram_byte_writes");
        for (int k = 0; k < 64; k++) begin
            idx = int'(rand_bits(8)) % `SYS_RAM_WORDS;
            // Fill an unseen word fully so every lane is known
            if (!ram_known[idx]) begin
                d = rand_bits(32);
                bus_write(reg_addr(`SYS_BASE_RAM, idx * 4), d, 4'hF);
                ram_model[idx] = d;
                ram_known[idx] = 1'b1;
            end
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            if (s == 4'h0) s = 4'hF;
            bus_write(reg_addr(`SYS_BASE_RAM, idx * 4), d, s);
            m              = lane_mask(s);
            ram_model[idx] = (ram_model[idx] & ~m) | (d & m);
            bus_read(reg_addr(`SYS_BASE_RAM, idx * 4), v);
            compare_word("read back", ram_model[idx], v);
        end
        end_test();
    endtask

    task automatic gpio_out_oe();
        logic [31:0] d;
        logic [3:0]  s;
        logic [31:0] v;
        begin_test("gpio_out_oe");
        for (int k = 0; k < 8; k++) begin
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            bus_write(reg_addr(`SYS_BASE_GPIO, `GPIO_REG_OUT), d, s);
            out_model = (out_model & ~lane_mask(s)) | (d & lane_mask(s));
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            bus_write(reg_addr(`SYS_BASE_GPIO, `GPIO_REG_OE), d, s);
            oe_model = (oe_model & ~lane_mask(s)) | (d & lane_mask(s));
            // Pads first and then the register view
            compare_word("gpio_out pins", out_model, gpio_out);
            compare_word("gpio_oe pins", oe_model, gpio_oe);
            bus_read(reg_addr(`SYS_BASE_GPIO, `GPIO_REG_OUT), v);
            compare_word("OUT read", out_model, v);
            bus_read(reg_addr(`SYS_BASE_GPIO, `GPIO_REG_OE), v);
            compare_word("OE read", oe_model, v);
        end
        end_test();
    endtask

    task automatic gpio_in_sync();
        logic [31:0] pads;
        logic [31:0] v;
        begin_test("gpio_in_sync");
        for (int k = 0; k < 8; k++) begin
            pads    = rand_bits(32);
            gpio_in = pads;
            // Two synchronizer stages plus margin
            repeat (3) @(negedge clk);
            bus_read(reg_addr(`SYS_BASE_GPIO, `GPIO_REG_IN), v);
            compare_word("IN read", pads, v);
            bus_write(reg_addr(`SYS_BASE_GPIO, `GPIO_REG_IN), rand_bits(32), 4'hF);
            bus_read(reg_addr(`SYS_BASE_GPIO, `GPIO_REG_IN), v);
            compare_word("IN after write", pads, v);
        end
        end_test();
    endtask

    task automatic timer_one_shot();
        int          n;
        logic [31:0] v;
        begin_test("timer_one_shot");
        for (int k = 0; k < 4; k++) begin
            n = 5 + int'(rand_bits(8) % 32'd36);
            bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_LOAD), 32'(n), 4'hF);
            // Enable and interrupt enable without reload
            bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_CTRL), 32'h5, 4'hF);
            for (int c = 1; c < n; c++) begin
                @(negedge clk);
                compare_bit("irq before expiry", 1'b0, irq);
            end
            wait_irq(4);
            bus_read(reg_addr(`SYS_BASE_TIMER, `TMR_REG_COUNT), v);
            compare_word("COUNT at expiry", 32'h0, v);
            compare_bit("irq held", 1'b1, irq);
            // Write one to clear
            bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_STATUS), 32'h1, 4'hF);
            compare_bit("irq after clear", 1'b0, irq);
            bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_CTRL), 32'h0, 4'hF);
        end
        end_test();
    endtask

    task automatic timer_auto_reload();
        int          n;
        logic [31:0] v;
        begin_test("timer_auto_reload");
        n = 8 + int'(rand_bits(4));
        bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_LOAD), 32'(n), 4'hF);
        bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_CTRL), 32'h7, 4'hF);
        wait_irq(n + 4);
        bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_STATUS), 32'h1, 4'hF);
        compare_bit("irq after clear", 1'b0, irq);
        // Reload keeps the count within LOAD
        repeat (6) begin
            bus_read(reg_addr(`SYS_BASE_TIMER, `TMR_REG_COUNT), v);
            compare_bit("COUNT within LOAD", 1'b1, v <= 32'(n));
        end
        wait_irq(n + 4);
        bus_read(reg_addr(`SYS_BASE_TIMER, `TMR_REG_STATUS), v);
        compare_word("expired again", 32'h1, v);
        bus_write(reg_addr(`SYS_BASE_TIMER, `TMR_REG_CTRL), 32'h0, 4'hF);
        bus_read(reg_addr(`SYS_BASE_TIMER, `TMR_REG_STATUS), v);
        compare_word("expired after disable", 32'h0, v);
        end_test();
    endtask

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        bus_fwd   = '0;
        gpio_in   = '0;
        lfsr_q    = 16'd33;
        out_model = '0;
        oe_model  = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        tests_bad = 0;
        for (int i = 0; i < `SYS_RAM_WORDS; i++) ram_known[i] = 1'b0;
        reset_release();
        ram_byte_writes();
        gpio_out_oe();
        gpio_in_sync();
        timer_one_shot();
        timer_auto_reload();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sys_top.f
+incdir+design
design/sys_pkg.sv
design/reset_gen.sv
design/bram_port.sv
design/gpio_regs.sv
design/timer_irq.sv
design/sys_top.sv
tb/sys_top_sva.sv
tb/sys_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := sys_top_tb
FILELIST  := sys_top.f
OBJDIR    := obj_dir
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
